//--- common/execPkg.sv
`default_nettype none

package execPkg;

   // Execute unit operations
   typedef enum logic [4:0] {
      opAdd,
      opAddc,
      opSub,
      opSubc,
      opCmpu,
      opOr,
      opAnd,
      opXor,
      opAndn,
      opSra,
      opSrc,
      opSrl,
      opSext8,
      opSext16,
      opMfs,
      opMfpc,
      opMts,
      opMul,
      opBsrl,
      opBsra,
      opBsll,
      opLdSt,
      opInt,
      opBrk,
      opRtid,
      opRtbd
   } aluOpE;

   typedef enum logic [1:0] {srcRegA, srcFwd, srcLoad, srcPc} srcASelE;

   typedef enum logic [1:0] {srcRegB, srcFwdB, srcLoadB, srcImm} srcBSelE;

   typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSizeE;

   // One decoded operation from decode
   typedef struct packed {
      logic        strobe;    // High one cycle per operation
      aluOpE       op;
      srcASelE     srcA;
      srcBSelE     srcB;
      memSizeE     memSize;
      logic [31:0] regA;
      logic [31:0] regB;
      logic [31:0] imm;       // Already sign-extended
      logic [31:0] loadData;
      logic [29:0] pc;        // Word address
   } execIssueT;

   typedef struct packed {
      logic        valid;
      aluOpE       op;
      logic [31:0] aluResult;
      logic [3:0]  byteSel;
   } stage1T;

   typedef struct packed {
      logic carry;
      logic intEnable;
      logic breakInProg;
      logic bigEndian;
   } msrT;

   // Bit positions in the MSR word
   localparam int msrCarryBit     = 2;
   localparam int msrIeBit        = 1;
   localparam int msrBipBit       = 3;
   localparam int msrBeBit        = 0;
   localparam int msrCarryCopyBit = 31;  // Carry mirrored in the top bit

endpackage

`default_nettype wire

//--- source/operandSelect.sv
`default_nettype none
`timescale 1ns/10ps

module operandSelect import execPkg::*; (
   input  execIssueT   issue,
   input  logic [31:0] fwdResult,
   output logic [31:0] opA,
   output logic [31:0] opB
);

   // Operand A mux
   always_comb begin
      case (issue.srcA)
         srcRegA: opA = issue.regA;
         srcFwd:  opA = fwdResult;          // Last completed result
         srcLoad: opA = issue.loadData;
         srcPc:   opA = {issue.pc, 2'b00};  // Byte address of the pc
         default: opA = issue.regA;
      endcase
   end

   // Operand B mux, immediate in place of the pc
   always_comb begin
      case (issue.srcB)
         srcRegB:  opB = issue.regB;
         srcFwdB:  opB = fwdResult;
         srcLoadB: opB = issue.loadData;
         srcImm:   opB = issue.imm;
         default:  opB = issue.regB;
      endcase
   end

endmodule

`default_nettype wire

//--- alu/aluCore.sv
`default_nettype none
`timescale 1ns/10ps

module aluCore import execPkg::*; (
   input  aluOpE       op,
   input  memSizeE     memSize,
   input  logic [31:0] opA,
   input  logic [31:0] opB,
   input  msrT         msr,
   input  logic [29:0] pc,
   output logic [31:0] aluResult,
   output logic        carryOut,
   output logic [3:0]  byteSel,
   output logic [29:0] memAddr
);

   logic        isSub;
   logic        useCarry;
   logic        carryIn;
   logic        addCarry;
   logic        shiftIn;
   logic        isShift;
   logic [31:0] addA;
   logic [31:0] addSum;
   logic [31:0] msrWord;

   assign isSub    = (op == opSub) || (op == opSubc) || (op == opCmpu);
   assign useCarry = (op == opAddc) || (op == opSubc);
   assign carryIn  = useCarry ? msr.carry : isSub;  // Plain sub adds the one itself
   assign addA     = isSub ? ~opA : opA;

   // Computes B + A or B - A
   assign {addCarry, addSum} = {1'b0, opB} + {1'b0, addA} + {32'd0, carryIn};

   assign memAddr = addSum[31:2];  // Pre-cycle cache address

   assign isShift = (op == opSra) || (op == opSrc) || (op == opSrl);

   always_comb begin
      case (op)
         opSra:   shiftIn = opA[31];
         opSrc:   shiftIn = msr.carry;  // Rotate through carry
         default: shiftIn = 1'b0;
      endcase
   end

   assign carryOut = isShift ? opA[0] : addCarry;

   // Version field reads as zero
   always_comb begin
      msrWord                  = '0;
      msrWord[msrCarryBit]     = msr.carry;
      msrWord[msrIeBit]        = msr.intEnable;
      msrWord[msrBipBit]       = msr.breakInProg;
      msrWord[msrBeBit]        = msr.bigEndian;
      msrWord[msrCarryCopyBit] = msr.carry;
   end

   always_comb begin
      case (op)
         opAdd, opAddc, opSub, opSubc, opLdSt: aluResult = addSum;
         opCmpu:   aluResult = {~addCarry, addSum[30:0]};  // Unsigned A > B in the top bit
         opOr:     aluResult = opA | opB;
         opAnd:    aluResult = opA & opB;
         opXor:    aluResult = opA ^ opB;
         opAndn:   aluResult = opA & ~opB;
         opSra, opSrc, opSrl: aluResult = {shiftIn, opA[31:1]};
         opSext8:  aluResult = {{24{opA[7]}}, opA[7:0]};
         opSext16: aluResult = {{16{opA[15]}}, opA[15:0]};
         opMfs:    aluResult = msrWord;
         opMfpc:   aluResult = {pc, 2'b00};
         opMts:    aluResult = opA;  // Value written to the MSR
         default:  aluResult = '0;   // Mul and barrel results join in stage 2
      endcase
   end

   // Byte lanes, big-endian order
   always_comb begin
      byteSel = 4'h0;
      if (op == opLdSt) begin
         case (memSize)
            sizeByte: begin
               case (addSum[1:0])
                  2'd0: byteSel = 4'h8;
                  2'd1: byteSel = 4'h4;
                  2'd2: byteSel = 4'h2;
                  default: byteSel = 4'h1;
               endcase
            end
            sizeHalf: byteSel = addSum[1] ? 4'h3 : 4'hC;
            sizeWord: byteSel = 4'hF;
            default:  byteSel = 4'h0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- alu/mulShift.sv
`default_nettype none
`timescale 1ns/10ps

module mulShift #(
   parameter int hasMul    = 1,
   parameter int hasBarrel = 1
) (
   input  logic        gclk,
   input  logic        grst,
   input  logic        strobe,
   input  logic [31:0] opA,
   input  logic [31:0] opB,
   output logic [31:0] product,
   output logic [31:0] shiftRight,
   output logic [31:0] shiftArith,
   output logic [31:0] shiftLeft
);

   generate
      if (hasMul != 0) begin : genMul
         always_ff @(posedge gclk) begin
            if (grst) begin
               product <= '0;
            end else if (strobe) begin
               product <= opA * opB;  // Low word only
            end
         end
      end else begin : genNoMul
         assign product = '0;
      end

      if (hasBarrel != 0) begin : genBarrel
         // All three shifts are captured, stage 2 picks one by op
         always_ff @(posedge gclk) begin
            if (grst) begin
               shiftRight <= '0;
               shiftArith <= '0;
               shiftLeft  <= '0;
            end else if (strobe) begin
               shiftRight <= opA >> opB[4:0];
               shiftArith <= $unsigned($signed(opA) >>> opB[4:0]);
               shiftLeft  <= opA << opB[4:0];
            end
         end
      end else begin : genNoBarrel
         assign shiftRight = '0;
         assign shiftArith = '0;
         assign shiftLeft  = '0;
      end
   endgenerate

   // Stage 2 reads these a cycle after issue
   property pKnownOutputs;
      @(posedge gclk) disable iff (grst)
         !$isunknown({product, shiftRight, shiftArith, shiftLeft});
   endproperty

   assert property (pKnownOutputs)
      else $error("mulShift: unknown output after reset");

endmodule

`default_nettype wire

//--- source/statusReg.sv
`default_nettype none
`timescale 1ns/10ps

module statusReg import execPkg::*; (
   input  logic        gclk,
   input  logic        grst,
   input  logic        strobe,
   input  aluOpE       op,
   input  logic [31:0] opA,
   input  logic        carryOut,
   output msrT         msr
);

   msrT msrNext;

   always_comb begin
      msrNext = msr;
      case (op)
         opAdd, opAddc, opSub, opSubc: begin
            msrNext.carry = carryOut;  // Adder carry, cmpu leaves it alone
         end
         opSra, opSrc, opSrl: begin
            msrNext.carry = carryOut;  // Bit shifted out
         end
         opMts: begin
            msrNext.carry       = opA[msrCarryBit];
            msrNext.intEnable   = opA[msrIeBit];
            msrNext.breakInProg = opA[msrBipBit];
            msrNext.bigEndian   = opA[msrBeBit];
         end
         opInt:  msrNext.intEnable   = 1'b0;
         opRtid: msrNext.intEnable   = 1'b1;
         opBrk:  msrNext.breakInProg = 1'b1;
         opRtbd: msrNext.breakInProg = 1'b0;
         default: begin
         end
      endcase
   end

   // Only issued operations touch the MSR
   always_ff @(posedge gclk) begin
      if (grst) begin
         msr <= '0;
      end else if (strobe) begin
         msr <= msrNext;
      end
   end

   // Interrupt entry and return land on a fixed IE value
   property pIeUpdate;
      @(posedge gclk) disable iff (grst)
         (strobe && (op == opInt || op == opRtid))
            |=> (msr.intEnable == $past(op == opRtid));
   endproperty

   assert property (pIeUpdate)
      else $error("statusReg: intEnable not updated by int or rtid");

endmodule

`default_nettype wire

//--- source/resultStage.sv
`default_nettype none
`timescale 1ns/10ps

module resultStage import execPkg::*; #(
   parameter int hasMul    = 1,
   parameter int hasBarrel = 1
) (
   input  logic        gclk,
   input  logic        grst,
   input  stage1T      stage1,
   input  logic [31:0] product,
   input  logic [31:0] shiftRight,
   input  logic [31:0] shiftArith,
   input  logic [31:0] shiftLeft,
   output logic [31:0] result,
   output logic [3:0]  byteSel,
   output logic        resValid
);

   stage1T      stage1Q;
   logic [31:0] finalValue;

   always_ff @(posedge gclk) begin
      if (grst) begin
         stage1Q.valid <= 1'b0;
      end else begin
         stage1Q.valid <= stage1.valid;
      end
      stage1Q.op        <= stage1.op;
      stage1Q.aluResult <= stage1.aluResult;
      stage1Q.byteSel   <= stage1.byteSel;
   end

   always_comb begin
      case (stage1Q.op)
         opMul:   finalValue = (hasMul != 0) ? product : '0;
         opBsrl:  finalValue = (hasBarrel != 0) ? shiftRight : '0;
         opBsra:  finalValue = (hasBarrel != 0) ? shiftArith : '0;
         opBsll:  finalValue = (hasBarrel != 0) ? shiftLeft : '0;
         default: finalValue = stage1Q.aluResult;
      endcase
   end

   // Result holds until the next completed operation
   always_ff @(posedge gclk) begin
      if (grst) begin
         result   <= '0;
         byteSel  <= '0;
         resValid <= 1'b0;
      end else begin
         resValid <= stage1Q.valid;
         if (stage1Q.valid) begin
            result  <= finalValue;
            byteSel <= stage1Q.byteSel;
         end
      end
   end

   assert property (@(posedge gclk) disable iff (grst)
      (!$past(grst) && !$past(grst, 2)) |-> (resValid == $past(stage1.valid, 2)))
      else $error("resultStage: resValid not two cycles after issue");

endmodule

`default_nettype wire

//--- source/execStage.sv
`default_nettype none
`timescale 1ns/10ps

module execStage import execPkg::*; #(
   parameter int hasMul    = 1,
   parameter int hasBarrel = 1
) (
   input  logic        gclk,
   input  logic        grst,
   input  execIssueT   issue,
   output logic [31:0] result,
   output logic        resValid,
   output logic [3:0]  byteSel,
   output logic [29:0] memAddr,
   output logic        msrIe
);

   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] aluResult;
   logic        carryOut;
   logic [3:0]  aluByteSel;
   logic [31:0] product;
   logic [31:0] shiftRight;
   logic [31:0] shiftArith;
   logic [31:0] shiftLeft;
   msrT         msr;
   stage1T      stage1;

   assign stage1 = '{valid: issue.strobe, op: issue.op, aluResult: aluResult,
                     byteSel: aluByteSel};
   assign msrIe  = msr.intEnable;

   operandSelect operandSelect_inst (.issue(issue), .fwdResult(result), .opA(opA), .opB(opB));

   aluCore aluCore_inst (.op(issue.op), .memSize(issue.memSize), .opA(opA), .opB(opB),
      .msr(msr), .pc(issue.pc), .aluResult(aluResult), .carryOut(carryOut),
      .byteSel(aluByteSel), .memAddr(memAddr));

   mulShift #(.hasMul(hasMul), .hasBarrel(hasBarrel)) mulShift_inst (.gclk(gclk),
      .grst(grst), .strobe(issue.strobe), .opA(opA), .opB(opB), .product(product),
      .shiftRight(shiftRight), .shiftArith(shiftArith), .shiftLeft(shiftLeft));

   statusReg statusReg_inst (.gclk(gclk), .grst(grst), .strobe(issue.strobe), .op(issue.op),
      .opA(opA), .carryOut(carryOut), .msr(msr));

   resultStage #(.hasMul(hasMul), .hasBarrel(hasBarrel)) resultStage_inst (.gclk(gclk),
      .grst(grst), .stage1(stage1), .product(product), .shiftRight(shiftRight),
      .shiftArith(shiftArith), .shiftLeft(shiftLeft), .result(result), .byteSel(byteSel),
      .resValid(resValid));

endmodule

`default_nettype wire

//--- verification/execStageTb.sv
`default_nettype none
`timescale 1ns/10ps

module execStageTb import execPkg::*;;

   typedef struct {
      aluOpE       op;
      srcASelE     srcA;
      srcBSelE     srcB;
      memSizeE     size;
      logic [31:0] regA;
      logic [31:0] regB;
      logic [31:0] imm;
      logic [31:0] loadData;
      logic [29:0] pc;
      int          gap;        // Idle cycles after this row
      int          issueEdge;
      logic [31:0] expResult;
      logic [3:0]  expByteSel;
      logic [29:0] expMemAddr;
      logic        expIe;
   } rowT;

   logic        gclk;
   logic        grst;
   execIssueT   issue;
   logic [31:0] result;
   logic        resValid;
   logic [3:0]  byteSel;
   logic [29:0] memAddr;
   logic        msrIe;

   rowT         rows[$];
   int          pending[$];   // Rows in flight, oldest first
   int          edgeCount = 0;
   int          lastIssued = -1;
   bit          tableBuilt = 1'b0;

   execStage #(.hasMul(1), .hasBarrel(1)) execStage_inst (.gclk(gclk), .grst(grst),
      .issue(issue), .result(result), .resValid(resValid), .byteSel(byteSel),
      .memAddr(memAddr), .msrIe(msrIe));

   initial begin
      gclk = 1'b0;
      forever #10 gclk = ~gclk;
   end

   always @(posedge gclk) edgeCount <= edgeCount + 1;

   task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "check on %s failed", name);
      end
   endtask

   task automatic addRow(aluOpE op, srcASelE sa, srcBSelE sb, memSizeE size,
                         logic [31:0] a, logic [31:0] b, int gap);
      rowT r;
      r.op         = op;
      r.srcA       = sa;
      r.srcB       = sb;
      r.size       = size;
      r.regA       = a;
      r.regB       = b;
      r.imm        = $urandom();
      r.loadData   = $urandom();
      r.pc         = 30'($urandom());
      r.gap        = gap;
      r.issueEdge  = 0;
      r.expResult  = '0;
      r.expByteSel = '0;
      r.expMemAddr = '0;
      r.expIe      = 1'b0;
      rows.push_back(r);
   endtask

   // Reference model, walks the rows in issue order
   task automatic computeExpected();
      msrT         m;
      logic [31:0] last;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [32:0] wide;
      m    = '0;
      last = '0;  // Result register after reset
      for (int i = 0; i < rows.size(); i++) begin
         case (rows[i].srcA)
            srcFwd:  a = last;
            srcLoad: a = rows[i].loadData;
            srcPc:   a = {rows[i].pc, 2'b00};
            default: a = rows[i].regA;
         endcase
         case (rows[i].srcB)
            srcFwdB:  b = last;
            srcLoadB: b = rows[i].loadData;
            srcImm:   b = rows[i].imm;
            default:  b = rows[i].regB;
         endcase
         case (rows[i].op)
            opAddc:        wide = {1'b0, b} + {1'b0, a} + {32'd0, m.carry};
            opSub, opCmpu: wide = {1'b0, b} + {1'b0, ~a} + 33'd1;
            opSubc:        wide = {1'b0, b} + {1'b0, ~a} + {32'd0, m.carry};
            default:       wide = {1'b0, b} + {1'b0, a};
         endcase
         case (rows[i].op)
            opAdd, opAddc, opSub, opSubc, opLdSt: res = wide[31:0];
            opCmpu:   res = {~wide[32], wide[30:0]};
            opOr:     res = a | b;
            opAnd:    res = a & b;
            opXor:    res = a ^ b;
            opAndn:   res = a & ~b;
            opSra:    res = {a[31], a[31:1]};
            opSrc:    res = {m.carry, a[31:1]};  // Old carry rotates in
            opSrl:    res = {1'b0, a[31:1]};
            opSext8:  res = 32'($signed(a[7:0]));
            opSext16: res = 32'($signed(a[15:0]));
            opMfs: begin
               res                  = '0;
               res[msrCarryBit]     = m.carry;
               res[msrIeBit]        = m.intEnable;
               res[msrBipBit]       = m.breakInProg;
               res[msrBeBit]        = m.bigEndian;
               res[msrCarryCopyBit] = m.carry;
            end
            opMfpc:   res = {rows[i].pc, 2'b00};
            opMts:    res = a;
            opMul:    res = a * b;
            opBsrl:   res = a >> b[4:0];
            opBsra:   res = $signed(a) >>> b[4:0];
            opBsll:   res = a << b[4:0];
            default:  res = '0;
         endcase
         if (rows[i].op == opLdSt) begin
            case (rows[i].size)
               sizeByte: rows[i].expByteSel = 4'h8 >> wide[1:0];
               sizeHalf: rows[i].expByteSel = wide[1] ? 4'h3 : 4'hC;
               default:  rows[i].expByteSel = 4'hF;
            endcase
            rows[i].expMemAddr = wide[31:2];
         end
         case (rows[i].op)
            opAdd, opAddc, opSub, opSubc: m.carry = wide[32];
            opSra, opSrc, opSrl: m.carry = a[0];
            opMts: m = '{carry: a[msrCarryBit], intEnable: a[msrIeBit],
                         breakInProg: a[msrBipBit], bigEndian: a[msrBeBit]};
            opInt:  m.intEnable   = 1'b0;
            opRtid: m.intEnable   = 1'b1;
            opBrk:  m.breakInProg = 1'b1;
            opRtbd: m.breakInProg = 1'b0;
            default: ;
         endcase
         rows[i].expResult = res;
         rows[i].expIe     = m.intEnable;
         last              = res;
      end
   endtask

   task automatic buildTable();
      addRow(opAdd, srcRegA, srcRegB, sizeWord, 32'hFFFF_FFF0, 32'h0000_0020, 0);  // Overflows
      addRow(opAddc, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opSub, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opSubc, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opCmpu, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opAddc, srcRegA, srcImm, sizeWord, $urandom(), 32'd0, 0);
      addRow(opOr, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opAnd, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opXor, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opAndn, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opSrl, srcRegA, srcRegB, sizeWord, 32'h8000_0001, 32'd0, 0);  // Leaves carry set
      addRow(opSrc, srcRegA, srcRegB, sizeWord, $urandom(), 32'd0, 0);
      addRow(opSra, srcRegA, srcRegB, sizeWord, $urandom() | 32'h8000_0000, 32'd0, 0);
      addRow(opSrc, srcRegA, srcRegB, sizeWord, $urandom(), 32'd0, 0);
      addRow(opSext8, srcRegA, srcRegB, sizeWord, $urandom() | 32'h80, 32'd0, 0);
      addRow(opSext16, srcRegA, srcRegB, sizeWord, $urandom(), 32'd0, 0);
      // Operand sources, forwarding rows three cycles apart
      addRow(opAdd, srcLoad, srcImm, sizeWord, $urandom(), $urandom(), 0);
      addRow(opOr, srcPc, srcLoadB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opMfpc, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opXor, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 2);
      addRow(opAdd, srcFwd, srcImm, sizeWord, $urandom(), $urandom(), 2);
      addRow(opSub, srcLoad, srcFwdB, sizeWord, $urandom(), $urandom(), 2);
      addRow(opAnd, srcFwd, srcFwdB, sizeWord, $urandom(), $urandom(), 0);
      // MSR traffic
      addRow(opMts, srcRegA, srcRegB, sizeWord, $urandom(), 32'd0, 0);
      addRow(opMfs, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opMts, srcRegA, srcRegB, sizeWord, 32'h0000_000F, 32'd0, 0);
      addRow(opMfs, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opInt, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opRtid, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opInt, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opRtbd, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opMfs, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opBrk, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opMfs, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      addRow(opRtid, srcRegA, srcRegB, sizeWord, 32'd0, 32'd0, 0);
      // Mul and barrel shifts back to back
      addRow(opMul, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opBsrl, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opBsra, srcRegA, srcRegB, sizeWord, $urandom() | 32'h8000_0000, $urandom(), 0);
      addRow(opBsll, srcRegA, srcRegB, sizeWord, $urandom(), $urandom(), 0);
      addRow(opMul, srcLoad, srcImm, sizeWord, $urandom(), $urandom(), 0);
      for (int off = 0; off < 4; off++) begin
         addRow(opLdSt, srcRegA, srcRegB, sizeByte, ($urandom() & 32'hFFFF_FFFC) | off,
                $urandom() & 32'hFFFF_FFFC, 0);
      end
      for (int off = 0; off < 4; off += 2) begin
         addRow(opLdSt, srcRegA, srcRegB, sizeHalf, ($urandom() & 32'hFFFF_FFFC) | off,
                $urandom() & 32'hFFFF_FFFC, 0);
      end
      addRow(opLdSt, srcRegA, srcImm, sizeWord, $urandom() & 32'hFFFF_FFFC, 32'd0, 0);
   endtask

   // One clock of stimulus, idx below zero leaves the strobe low
   task automatic driveCycle(int idx);
      @(posedge gclk);
      #2;
      if (lastIssued >= 0) begin
         checkValue("msrIe", {31'd0, msrIe}, {31'd0, rows[lastIssued].expIe});
      end
      lastIssued = idx;
      if (idx < 0) begin
         issue.strobe = 1'b0;
      end else begin
         issue.strobe   = 1'b1;
         issue.op       = rows[idx].op;
         issue.srcA     = rows[idx].srcA;
         issue.srcB     = rows[idx].srcB;
         issue.memSize  = rows[idx].size;
         issue.regA     = rows[idx].regA;
         issue.regB     = rows[idx].regB;
         issue.imm      = rows[idx].imm;
         issue.loadData = rows[idx].loadData;
         issue.pc       = rows[idx].pc;
         rows[idx].issueEdge = edgeCount;  // Edge the row is launched after
         pending.push_back(idx);
         if (rows[idx].op == opLdSt) begin
            #1;
            checkValue("memAddr", {2'b00, memAddr}, {2'b00, rows[idx].expMemAddr});
         end
      end
   endtask

   // Results due two edges after launch, otherwise resValid stays low
   always @(negedge gclk) begin
      int idx;
      if (!grst) begin
         if (pending.size() > 0 && rows[pending[0]].issueEdge + 2 == edgeCount) begin
            idx = pending.pop_front();
            checkValue("resValid", {31'd0, resValid}, 32'd1);
            checkValue("result", result, rows[idx].expResult);
            checkValue("byteSel", {28'd0, byteSel}, {28'd0, rows[idx].expByteSel});
         end else begin
            checkValue("resValid", {31'd0, resValid}, 32'd0);
         end
      end
   end

   initial begin
      wait (tableBuilt);
      repeat (rows.size() * 5 + 50) @(posedge gclk);
      $display("Timeout: the DUT did not deliver every result in time");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h1bb2));
      grst      = 1'b1;
      issue     = '0;
      repeat (2) @(posedge gclk);
      #2 grst = 1'b0;
      @(negedge gclk);
      checkValue("result", result, 32'd0);
      checkValue("byteSel", {28'd0, byteSel}, 32'd0);
      checkValue("resValid", {31'd0, resValid}, 32'd0);
      checkValue("memAddr", {2'b00, memAddr}, 32'd0);
      checkValue("msrIe", {31'd0, msrIe}, 32'd0);
      buildTable();
      computeExpected();
      tableBuilt = 1'b1;
      for (int i = 0; i < rows.size(); i++) begin
         driveCycle(i);
         for (int g = 0; g < rows[i].gap; g++) begin
            driveCycle(-1);
         end
      end
      driveCycle(-1);
      while (pending.size() != 0) begin
         @(posedge gclk);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- execStage.f
common/execPkg.sv
source/operandSelect.sv
alu/aluCore.sv
alu/mulShift.sv
source/statusReg.sv
source/resultStage.sv
source/execStage.sv
verification/execStageTb.sv

//--- runSim.sh
#!/bin/sh
# Compile the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module execStageTb \
   -f execStage.f \
   -o execStageSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/execStageSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
